/* Makefile */
# Verilator build and run of the Blackbone tile testbench

SRCS := project.f $(wildcard src/*.sv) $(wildcard test/*.sv)

.PHONY: run clean

run: obj_dir/Vtb_bb_tile
	./obj_dir/Vtb_bb_tile | tee sim.log
	grep -q "TEST PASSED" sim.log

obj_dir/Vtb_bb_tile: $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module tb_bb_tile -f project.f

clean:
	rm -rf obj_dir sim.log

/* project.f */
src/bb_bus_pkg.sv
src/tile_map_pkg.sv
src/bb_sram_sp.sv
src/bb_bootrom.sv
src/bb_req_capture.sv
src/bb_bus_decode.sv
src/bb_resp_return.sv
src/bb_tile.sv
test/bb_tile_checker.sv
test/tb_bb_tile.sv

/* src/bb_bootrom.sv */
// Boot ROM
`timescale 1ns/100ps
`default_nettype none

module bb_bootrom import bb_bus_pkg::*, tile_map_pkg::*; #(
  parameter int unsigned DW = DW_DEF
) (
  input  wire                clk,
  input  wire                en_i,
  input  wire  [BOOT_AW-1:0] addr_i,
  output logic [DW-1:0]      dout_o
);

  // Contents follow the map rule
  always_ff @(posedge clk) begin
    if (en_i) begin
      dout_o <= DW'(boot_word(int'(addr_i)));
    end
  end

endmodule : bb_bootrom

`default_nettype wire

/* src/bb_bus_decode.sv */
// Address decode and slave routing
`timescale 1ns/100ps
`default_nettype none

module bb_bus_decode import bb_bus_pkg::*, tile_map_pkg::*; #(
  parameter int unsigned AW      = AW_DEF,
  parameter int unsigned DW      = DW_DEF,
  parameter int unsigned LMEM_AW = LMEM_AW_DEF
) (
  input  wire           clk,
  input  wire           arst_n_i,
  input  wire           bus_en_i,
  input  wire           bus_we_i,
  input  wire  [AW-1:0] bus_addr_i,
  input  wire  [DW-1:0] bus_wdata_i,
  input  wire  [DW-1:0] bb_ext_dout_i,
  output logic [AW-1:0] bb_ext_addr_o,
  output logic [DW-1:0] bb_ext_din_o,
  output logic          bb_ext_en_o,
  output logic          bb_ext_we_o,
  output logic          rd_valid_o,
  output logic [DW-1:0] rd_data_o
);

  //////////////////////////////////////////////////////////////////////
  // Request path
  //////////////////////////////////////////////////////////////////////

  slave_sel_e sel_d;

  logic          lmem_en;
  logic          boot_en;
  logic [DW-1:0] lmem_dout;
  logic [DW-1:0] boot_dout;

  always_comb begin
    case (bus_addr_i[AW-1 -: RANGE_W])
      LMEM_MATCH: sel_d = SLV_LMEM;
      BOOT_MATCH: sel_d = SLV_BOOT;
      EXT_MATCH:  sel_d = SLV_EXT;
      default:    sel_d = SLV_NONE;
    endcase
  end

  assign lmem_en     = bus_en_i && (sel_d == SLV_LMEM);
  assign boot_en     = bus_en_i && (sel_d == SLV_BOOT);
  assign bb_ext_en_o = bus_en_i && (sel_d == SLV_EXT);
  assign bb_ext_we_o = bb_ext_en_o && bus_we_i;

  assign bb_ext_addr_o = {{RANGE_W{1'b0}}, bus_addr_i[AW-RANGE_W-1:0]};  // Window offset
  assign bb_ext_din_o  = bus_wdata_i;

  bb_sram_sp #(
    .DW      (DW),
    .LMEM_AW (LMEM_AW)
  ) u_lmem (
    .clk    (clk),
    .en_i   (lmem_en),
    .we_i   (bus_we_i),
    .addr_i (bus_addr_i[LMEM_AW+1:2]),  // Word index
    .din_i  (bus_wdata_i),
    .dout_o (lmem_dout)
  );

  bb_bootrom #(
    .DW (DW)
  ) u_bootrom (
    .clk    (clk),
    .en_i   (boot_en),
    .addr_i (bus_addr_i[BOOT_AW+1:2]),
    .dout_o (boot_dout)
  );

  //////////////////////////////////////////////////////////////////////
  // Return path
  //////////////////////////////////////////////////////////////////////

  // Select follows the slave latency so it lines up with the data
  slave_sel_e              sel_sr [BUS_RD_LAT];
  logic [BUS_RD_LAT-1:0]   vld_sr;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      vld_sr <= '0;
      for (int i = 0; i < BUS_RD_LAT; i++) begin
        sel_sr[i] <= SLV_NONE;
      end
    end else begin
      vld_sr[0] <= bus_en_i;
      sel_sr[0] <= (bus_en_i && !bus_we_i) ? sel_d : SLV_NONE;  // Writes return zero
      for (int i = 1; i < BUS_RD_LAT; i++) begin
        vld_sr[i] <= vld_sr[i-1];
        sel_sr[i] <= sel_sr[i-1];
      end
    end
  end

  assign rd_valid_o = vld_sr[BUS_RD_LAT-1];

  always_comb begin
    case (sel_sr[BUS_RD_LAT-1])
      SLV_LMEM: rd_data_o = lmem_dout;
      SLV_BOOT: rd_data_o = boot_dout;
      SLV_EXT:  rd_data_o = bb_ext_dout_i;
      default:  rd_data_o = '0;
    endcase
  end

  a_one_target : assert property (
    @(posedge clk) disable iff (!arst_n_i) $onehot0({lmem_en, boot_en, bb_ext_en_o})
  );

endmodule : bb_bus_decode

`default_nettype wire

/* src/bb_bus_pkg.sv */
// Blackbone bus definitions
`default_nettype none

package bb_bus_pkg;

  //////////////////////////////////////////////////////////////////////
  // Default widths
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned AW_DEF      = 32;  // Byte address width
  localparam int unsigned DW_DEF      = 32;  // Data word width
  localparam int unsigned LMEM_AW_DEF = 8;   // 256 words of local memory

  //////////////////////////////////////////////////////////////////////
  // Slave select
  //////////////////////////////////////////////////////////////////////

  // Target of one bus access. SLV_NONE also marks writes on the return path.
  typedef enum logic [1:0] {
    SLV_LMEM,  // Local data memory
    SLV_BOOT,  // Boot ROM
    SLV_EXT,   // External memory window
    SLV_NONE   // Unmapped
  } slave_sel_e;

  //////////////////////////////////////////////////////////////////////
  // Bus timing
  //////////////////////////////////////////////////////////////////////

  // Cycles from slave enable to valid slave data
  localparam int unsigned BUS_RD_LAT = 1;

endpackage : bb_bus_pkg

`default_nettype wire

/* src/bb_req_capture.sv */
// Request capture
`timescale 1ns/100ps
`default_nettype none

module bb_req_capture import bb_bus_pkg::*; #(
  parameter int unsigned AW = AW_DEF,
  parameter int unsigned DW = DW_DEF
) (
  input  wire           clk,
  input  wire           arst_n_i,
  input  wire           req_i,
  input  wire           we_i,
  input  wire  [AW-1:0] addr_i,
  input  wire  [DW-1:0] wdata_i,
  input  wire           done_i,
  output logic          bus_en_o,
  output logic          bus_we_o,
  output logic [AW-1:0] bus_addr_o,
  output logic [DW-1:0] bus_wdata_o
);

  typedef enum logic [1:0] {
    CAP_IDLE,   // Armed, waiting for req
    CAP_BUSY,   // Access issued, waiting for ack
    CAP_DRAIN   // Ack seen, waiting for it to fall
  } cap_state_e;

  cap_state_e state_q;

  logic start;

  assign start = (state_q == CAP_IDLE) && req_i;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q  <= CAP_IDLE;
      bus_en_o <= 1'b0;
    end else begin
      bus_en_o <= start;  // One pulse per transaction
      case (state_q)
        CAP_IDLE:  if (req_i) state_q <= CAP_BUSY;
        CAP_BUSY:  if (done_i) state_q <= CAP_DRAIN;
        CAP_DRAIN: if (!done_i) state_q <= CAP_IDLE;  // Handshake closed
        default:   state_q <= CAP_IDLE;
      endcase
    end
  end

  // Request fields held for the whole access
  always_ff @(posedge clk) begin
    if (start) begin
      bus_we_o    <= we_i;
      bus_addr_o  <= addr_i;
      bus_wdata_o <= wdata_i;
    end
  end

  // A held req must not start a second access
  a_single_pulse : assert property (
    @(posedge clk) disable iff (!arst_n_i) bus_en_o |=> !bus_en_o
  );

endmodule : bb_req_capture

`default_nettype wire

/* src/bb_resp_return.sv */
// Response return
`timescale 1ns/100ps
`default_nettype none

module bb_resp_return import bb_bus_pkg::*; #(
  parameter int unsigned DW = DW_DEF
) (
  input  wire           clk,
  input  wire           arst_n_i,
  input  wire           req_i,
  input  wire           rd_valid_i,
  input  wire  [DW-1:0] rd_data_i,
  output logic          ack_o,
  output logic [DW-1:0] rdata_o,
  output logic          done_o
);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_o   <= 1'b0;
      rdata_o <= '0;
    end else if (rd_valid_i) begin
      ack_o   <= 1'b1;       // Data and ack leave together
      rdata_o <= rd_data_i;
    end else if (ack_o && !req_i) begin
      ack_o   <= 1'b0;       // Master closed the handshake
    end
  end

  assign done_o = ack_o;  // Capture rearms once this falls

  // Capture only issues on req, so the answer must find req still up
  a_ack_in_req : assert property (
    @(posedge clk) disable iff (!arst_n_i) $rose(ack_o) |-> $past(req_i)
  );

endmodule : bb_resp_return

`default_nettype wire

/* src/bb_sram_sp.sv */
// Single-port data memory
`timescale 1ns/100ps
`default_nettype none

module bb_sram_sp import bb_bus_pkg::*; #(
  parameter int unsigned DW      = DW_DEF,
  parameter int unsigned LMEM_AW = LMEM_AW_DEF
) (
  input  wire                clk,
  input  wire                en_i,
  input  wire                we_i,
  input  wire  [LMEM_AW-1:0] addr_i,
  input  wire  [DW-1:0]      din_i,
  output logic [DW-1:0]      dout_o
);

  localparam int unsigned WORDS = 2 ** LMEM_AW;

  logic [DW-1:0] mem [WORDS];

  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        mem[addr_i] <= din_i;
      end else begin
        dout_o <= mem[addr_i];  // Synchronous read
      end
    end
  end

endmodule : bb_sram_sp

`default_nettype wire

/* src/bb_tile.sv */
// Blackbone bus tile
`timescale 1ns/100ps
`default_nettype none

module bb_tile import bb_bus_pkg::*; #(
  parameter int unsigned AW      = AW_DEF,
  parameter int unsigned DW      = DW_DEF,
  parameter int unsigned LMEM_AW = LMEM_AW_DEF
) (
  input  wire           clk,
  input  wire           arst_n_i,

  // Master handshake
  input  wire           req_i,
  input  wire           we_i,
  input  wire  [AW-1:0] addr_i,
  input  wire  [DW-1:0] wdata_i,
  output logic          ack_o,
  output logic [DW-1:0] rdata_o,

  // External memory window
  output logic [AW-1:0] bb_ext_addr_o,
  output logic [DW-1:0] bb_ext_din_o,
  output logic          bb_ext_en_o,
  output logic          bb_ext_we_o,
  input  wire  [DW-1:0] bb_ext_dout_i
);

  //////////////////////////////////////////////////////////////////////
  // Internal bus
  //////////////////////////////////////////////////////////////////////

  logic          bus_en;
  logic          bus_we;
  logic [AW-1:0] bus_addr;
  logic [DW-1:0] bus_wdata;

  logic          rd_valid;
  logic [DW-1:0] rd_data;
  logic          done;

  bb_req_capture #(
    .AW (AW),
    .DW (DW)
  ) u_capture (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .req_i       (req_i),
    .we_i        (we_i),
    .addr_i      (addr_i),
    .wdata_i     (wdata_i),
    .done_i      (done),
    .bus_en_o    (bus_en),
    .bus_we_o    (bus_we),
    .bus_addr_o  (bus_addr),
    .bus_wdata_o (bus_wdata)
  );

  bb_bus_decode #(
    .AW      (AW),
    .DW      (DW),
    .LMEM_AW (LMEM_AW)
  ) u_bus (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .bus_en_i      (bus_en),
    .bus_we_i      (bus_we),
    .bus_addr_i    (bus_addr),
    .bus_wdata_i   (bus_wdata),
    .bb_ext_dout_i (bb_ext_dout_i),
    .bb_ext_addr_o (bb_ext_addr_o),
    .bb_ext_din_o  (bb_ext_din_o),
    .bb_ext_en_o   (bb_ext_en_o),
    .bb_ext_we_o   (bb_ext_we_o),
    .rd_valid_o    (rd_valid),
    .rd_data_o     (rd_data)
  );

  bb_resp_return #(
    .DW (DW)
  ) u_return (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .req_i      (req_i),
    .rd_valid_i (rd_valid),
    .rd_data_i  (rd_data),
    .ack_o      (ack_o),
    .rdata_o    (rdata_o),
    .done_o     (done)
  );

endmodule : bb_tile

`default_nettype wire

/* src/tile_map_pkg.sv */
// Tile address map
`default_nettype none

package tile_map_pkg;

  //////////////////////////////////////////////////////////////////////
  // Address ranges
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned RANGE_W = 4;  // Top address bits compared

  localparam logic [RANGE_W-1:0] LMEM_MATCH = 4'h0;  // Local data memory
  localparam logic [RANGE_W-1:0] EXT_MATCH  = 4'he;  // External window
  localparam logic [RANGE_W-1:0] BOOT_MATCH = 4'hf;  // Boot ROM

  //////////////////////////////////////////////////////////////////////
  // Boot ROM contents
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned BOOT_WORDS = 16;
  localparam int unsigned BOOT_AW    = $clog2(BOOT_WORDS);  // Word index width

  localparam logic [15:0] BOOT_TAG = 16'hb007;

  // Tag in the upper half, word index in the lower half
  function automatic logic [31:0] boot_word(input int unsigned idx);
    logic [15:0] wrapped;
    wrapped = 16'(idx % BOOT_WORDS);
    return {BOOT_TAG, wrapped};
  endfunction

endpackage : tile_map_pkg

`default_nettype wire

/* test/bb_tile_checker.sv */
// Tile response checker
`timescale 1ns/100ps
`default_nettype none

module bb_tile_checker import bb_bus_pkg::*, tile_map_pkg::*; (
  input  wire        clk,
  input  wire        arst_n_i,
  input  wire        req_i,
  input  wire        we_i,
  input  wire [31:0] addr_i,
  input  wire [31:0] wdata_i,
  input  wire        ack_i,
  input  wire [31:0] rdata_i,
  input  wire [31:0] ext_addr_i,
  input  wire [31:0] ext_din_i,
  input  wire        ext_en_i,
  input  wire        ext_we_i,
  output int         n_checks_o,
  output int         n_errors_o
);

  logic [31:0] lmem_model [2**LMEM_AW_DEF];  // Local memory contents
  logic [31:0] ext_model [logic [25:0]];     // Keyed by window word

  logic        in_txn;
  logic        txn_we;
  logic [31:0] txn_addr;
  logic [31:0] txn_wdata;
  logic        req_q;
  logic        ack_q;
  int          ext_pulses;
  int          checks = 0;
  int          errors = 0;

  assign n_checks_o = checks;
  assign n_errors_o = errors;

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] expected_read(input logic [31:0] addr);
    logic [LMEM_AW_DEF-1:0] idx;
    idx = LMEM_AW_DEF'(addr >> 2);  // Word index wraps at the memory size
    case (addr[31:28])
      LMEM_MATCH: return lmem_model[idx];
      BOOT_MATCH: return {BOOT_TAG, 16'((addr >> 2) % BOOT_WORDS)};
      EXT_MATCH:  return ext_model[addr[27:2]];
      default:    return '0;
    endcase
  endfunction

  task automatic value_mismatch(input string msg);
    $display("FAIL at %0t ns: %s", $time, msg);
    errors++;
  endtask

  task automatic protocol_error(input string msg);
    $display("Handshake error at %0t ns: %s", $time, msg);
    errors++;
  endtask

  task automatic inspect_ext_pulse();
    ext_pulses++;
    if (!in_txn || txn_addr[31:28] != EXT_MATCH) begin
      protocol_error("external enable seen outside an external access");
    end else begin
      if (ext_pulses > 1) protocol_error("second external access in one transaction");
      if (ext_addr_i !== {4'h0, txn_addr[27:0]})
        value_mismatch($sformatf("ext addr %h, expected %h", ext_addr_i, txn_addr[27:0]));
      if (ext_we_i !== txn_we)
        value_mismatch($sformatf("ext we %b, expected %b", ext_we_i, txn_we));
      if (txn_we && ext_din_i !== txn_wdata)
        value_mismatch($sformatf("ext din %h, expected %h", ext_din_i, txn_wdata));
    end
  endtask

  task automatic compare_response();
    logic [31:0] exp;
    checks++;
    if (!in_txn) protocol_error("ack rose without an open request");
    if (!req_q) protocol_error("ack rose while req was low");
    if (txn_addr[31:28] == EXT_MATCH && ext_pulses != 1)
      protocol_error($sformatf("%0d external enables in one external access", ext_pulses));
    exp = txn_we ? '0 : expected_read(txn_addr);
    if (rdata_i !== exp)
      value_mismatch($sformatf("%s addr %h: rdata %h, expected %h",
                               txn_we ? "write" : "read", txn_addr, rdata_i, exp));
    if (txn_we && txn_addr[31:28] == LMEM_MATCH) lmem_model[LMEM_AW_DEF'(txn_addr >> 2)] = txn_wdata;
    if (txn_we && txn_addr[31:28] == EXT_MATCH) ext_model[txn_addr[27:2]] = txn_wdata;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Port monitor
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (!arst_n_i) begin
      if (ack_i || ext_en_i) protocol_error("ack or external enable high during reset");
      in_txn = 1'b0;
      req_q  = 1'b0;
      ack_q  = 1'b0;
    end else begin
      if (!in_txn && req_i) begin  // New request opens
        in_txn     = 1'b1;
        txn_we     = we_i;
        txn_addr   = addr_i;
        txn_wdata  = wdata_i;
        ext_pulses = 0;
      end
      if (ext_en_i) inspect_ext_pulse();
      if (ack_i && !ack_q) compare_response();
      if (ack_q && req_q && !ack_i) protocol_error("ack dropped while req was held");
      if (ack_q && !req_q && ack_i) protocol_error("ack stayed high after req dropped");
      if (ack_q && !ack_i) in_txn = 1'b0;  // Handshake closed
      req_q = req_i;
      ack_q = ack_i;
    end
  end

endmodule : bb_tile_checker

`default_nettype wire

/* test/tb_bb_tile.sv */
// Blackbone tile testbench
`timescale 1ns/100ps
`default_nettype none

module tb_bb_tile;

  localparam int CLK_HALF    = 20;
  localparam int MAX_GAP     = 3;   // Idle cycles before a request
  localparam int MAX_HOLD    = 3;   // Extra cycles req stays up after ack
  localparam int PHASE_TXNS  = 40;
  localparam int N_TXNS      = 5 * PHASE_TXNS;
  localparam int WATCHDOG_NS = (16 + 10 + N_TXNS * (MAX_GAP + MAX_HOLD + 10)) * 2 * CLK_HALF;

  logic        clk      = 1'b0;
  logic        arst_n   = 1'b0;
  logic        req      = 1'b0;
  logic        we       = 1'b0;
  logic [31:0] addr     = '0;
  logic [31:0] wdata    = '0;
  logic [31:0] ext_dout = '0;
  logic        ack;
  logic [31:0] rdata;
  logic [31:0] ext_addr;
  logic [31:0] ext_din;
  logic        ext_en;
  logic        ext_we;

  int          n_checks;
  int          n_errors;
  int          checks_before = 0;
  int          errs_before   = 0;
  logic [31:0] lmem_addrs [$];            // Written local words
  logic [31:0] ext_addrs [$];             // Written external words
  logic [31:0] ext_mem [logic [25:0]];
  string       phase_names [5] = '{"local memory", "boot rom", "external window",
                                   "unmapped", "mixed"};

  always #(CLK_HALF) clk = ~clk;

  bb_tile #(
    .AW      (32),
    .DW      (32),
    .LMEM_AW (8)
  ) bb_tile_i (
    .clk           (clk),
    .arst_n_i      (arst_n),
    .req_i         (req),
    .we_i          (we),
    .addr_i        (addr),
    .wdata_i       (wdata),
    .ack_o         (ack),
    .rdata_o       (rdata),
    .bb_ext_addr_o (ext_addr),
    .bb_ext_din_o  (ext_din),
    .bb_ext_en_o   (ext_en),
    .bb_ext_we_o   (ext_we),
    .bb_ext_dout_i (ext_dout)
  );

  bb_tile_checker u_checker (
    .clk        (clk),
    .arst_n_i   (arst_n),
    .req_i      (req),
    .we_i       (we),
    .addr_i     (addr),
    .wdata_i    (wdata),
    .ack_i      (ack),
    .rdata_i    (rdata),
    .ext_addr_i (ext_addr),
    .ext_din_i  (ext_din),
    .ext_en_i   (ext_en),
    .ext_we_i   (ext_we),
    .n_checks_o (n_checks),
    .n_errors_o (n_errors)
  );

  // External memory model with one cycle of read latency
  always @(posedge clk) begin
    if (ext_en) begin
      if (ext_we) ext_mem[ext_addr[27:2]] = ext_din;
      else if (ext_mem.exists(ext_addr[27:2])) ext_dout <= #2 ext_mem[ext_addr[27:2]];
      else ext_dout <= #2 ext_addr ^ 32'h5a3c_c3a5;  // Fill for unwritten words
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Master stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic do_access(input logic w, input logic [31:0] a, input logic [31:0] d);
    int gap;
    int hold;
    gap  = $urandom % (MAX_GAP + 1);
    hold = $urandom % (MAX_HOLD + 1);
    repeat (gap) @(posedge clk);
    @(posedge clk);
    #2;
    req   = 1'b1;
    we    = w;
    addr  = a;
    wdata = d;
    do begin @(posedge clk); #2; end while (!ack);
    repeat (hold) begin @(posedge clk); #2; end
    req = 1'b0;
    do begin @(posedge clk); #2; end while (ack);
  endtask

  // Region 0 local, 1 boot, 2 external, 3 unmapped
  task automatic random_access(input int region);
    logic        w;
    logic [31:0] a;
    logic [31:0] d;
    w = 1'($urandom % 2);
    d = $urandom;
    case (region)
      0: begin
        if (w || lmem_addrs.size() == 0) begin
          w = 1'b1;
          a = $urandom & 32'h0ffc_007c;  // Upper bits alias onto 32 words
          lmem_addrs.push_back(a);
        end else a = lmem_addrs[$urandom % lmem_addrs.size()];
      end
      1: a = 32'hf000_0000 | ($urandom & 32'h0fff_fffc);
      2: begin
        if (w || ext_addrs.size() == 0) begin
          w = 1'b1;
          a = 32'he000_0000 | ($urandom & 32'h0300_003c);
          ext_addrs.push_back(a);
        end else a = ext_addrs[$urandom % ext_addrs.size()];
      end
      default: a = {4'(1 + $urandom % 13), 28'($urandom & 32'h0fff_fffc)};
    endcase
    do_access(w, a, d);
  endtask

  task automatic print_phase_result(input string name);
    $display("test %-16s %0d checks, %0d errors", name,
             n_checks - checks_before, n_errors - errs_before);
    checks_before = n_checks;
    errs_before   = n_errors;
  endtask

  initial begin
    void'($urandom(31902));
    repeat (16) @(posedge clk);
    #2;
    arst_n = 1'b1;
    repeat (4) @(posedge clk);
    print_phase_result("reset");
    for (int p = 0; p < 5; p++) begin
      for (int t = 0; t < PHASE_TXNS; t++) begin
        random_access(p < 4 ? p : int'($urandom % 4));  // Last phase mixes regions
      end
      print_phase_result(phase_names[p]);
    end
    repeat (4) @(posedge clk);
    $display("Summary: %0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("TEST FAILED");
    $finish;
  end

endmodule : tb_bb_tile

`default_nettype wire
